/* mem_pkg.sv */
package mem_pkg;

    localparam int NUM_SETS   = 256;    // sets per way
    localparam int LINE_BYTES = 16;     // bytes per cache line

    typedef logic [31:0]               word_t;      // data word
    typedef logic [31:0]               addr_t;      // byte address
    typedef logic [4:0]                reg_addr_t;  // gpr number
    typedef logic [19:0]               tag_t;       // addr[31:12]
    typedef logic [7:0]                index_t;     // addr[11:4]
    typedef logic [3:0]                offset_t;    // addr[3:0]
    typedef logic [LINE_BYTES*8-1:0]   line_t;      // word 0 in the low bits

    // nine ops do not fit in three bits, so the op field is four wide
    typedef enum logic [3:0] {
        MEM_NOP = 4'd0,     // no memory access
        MEM_LW  = 4'd1,
        MEM_LH  = 4'd2,     // sign extended
        MEM_LHU = 4'd3,     // zero extended
        MEM_LB  = 4'd4,     // sign extended
        MEM_LBU = 4'd5,     // zero extended
        MEM_SW  = 4'd6,
        MEM_SH  = 4'd7,
        MEM_SB  = 4'd8
    } mem_op_e;

    typedef enum logic [2:0] {
        DC_IDLE    = 3'd0,  // lookup, hits complete here
        DC_WB_REQ  = 3'd1,  // victim write, req high
        DC_WB_WAIT = 3'd2,  // req low, wait for ack low
        DC_RF_REQ  = 3'd3,  // refill read, req high
        DC_RF_WAIT = 3'd4,  // req low, wait for ack low
        DC_FILL    = 3'd5   // write refill line into the victim way
    } dc_state_e;

    typedef struct packed {
        logic      en;          // slot holds an instruction
        mem_op_e   op;          // memory operation
        addr_t     addr;        // alu result, also the access address
        word_t     wr_data;     // store data, right aligned
        reg_addr_t dst_addr;    // destination gpr
        logic      gpr_we;      // gpr write enable
    } ex_mem_t;

    typedef struct packed {
        logic      en;
        reg_addr_t dst_addr;
        logic      gpr_we;      // low on misalign
        word_t     out;         // load data or alu result
        logic      misalign;    // misaligned access flag
    } mem_wb_t;

    typedef struct packed {
        logic  we;              // 1 writeback, 0 refill
        addr_t addr;            // line address, offset zero
        line_t wdata;           // victim line for writes
    } l2_req_t;

endpackage

/* mem_align.sv */
`timescale 1ns/10ps

module mem_align import mem_pkg::*; (
    input  ex_mem_t ex,         // ex/mem fields
    input  line_t   hit_line,   // line of the hitting way
    output word_t   out,        // load result, alu result otherwise
    output line_t   st_line,    // hit line with store bytes merged in
    output logic    misalign,   // access off its natural boundary
    output logic    access,     // real cache access this cycle
    output logic    is_store    // sw, sh or sb
);

    offset_t     off;           // byte offset in the line
    word_t       rd_word;       // addressed word
    logic [15:0] rd_half;       // addressed half of that word
    logic [7:0]  rd_byte;       // addressed byte of that word
    word_t       st_rep;        // store data repeated over the lanes
    logic [3:0]  st_be;         // byte enables inside the word

    assign off     = ex.addr[3:0];
    assign rd_word = hit_line[off[3:2]*32 +: 32];
    assign rd_half = rd_word[off[1]*16 +: 16];
    assign rd_byte = rd_word[off[1:0]*8 +: 8];

    always_comb begin
        case (ex.op)
            MEM_LW, MEM_SW:          misalign = off[1:0] != 2'b00;   // word on 4 bytes
            MEM_LH, MEM_LHU, MEM_SH: misalign = off[0];              // half on 2 bytes
            default:                 misalign = 1'b0;
        endcase
    end

    assign is_store = (ex.op == MEM_SW) || (ex.op == MEM_SH) || (ex.op == MEM_SB);
    assign access   = ex.en && (ex.op != MEM_NOP) && !misalign;

    always_comb begin
        case (ex.op)
            MEM_LW:  out = rd_word;
            MEM_LH:  out = {{16{rd_half[15]}}, rd_half};
            MEM_LHU: out = {16'h0000, rd_half};
            MEM_LB:  out = {{24{rd_byte[7]}}, rd_byte};
            MEM_LBU: out = {24'h000000, rd_byte};
            default: out = ex.addr;                     // alu result passes through
        endcase
    end

    // lane data and enables, little endian inside the word
    always_comb begin
        case (ex.op)
            MEM_SW: begin
                st_rep = ex.wr_data;
                st_be  = 4'b1111;
            end
            MEM_SH: begin
                st_rep = {2{ex.wr_data[15:0]}};
                st_be  = off[1] ? 4'b1100 : 4'b0011;
            end
            MEM_SB: begin
                st_rep = {4{ex.wr_data[7:0]}};
                st_be  = 4'b0001 << off[1:0];
            end
            default: begin
                st_rep = ex.wr_data;
                st_be  = 4'b0000;                       // loads leave the line alone
            end
        endcase
    end

    always_comb begin
        st_line = hit_line;
        for (int b = 0; b < LINE_BYTES; b++) begin
            if ((b[3:2] == off[3:2]) && st_be[b[1:0]]) begin
                st_line[b*8 +: 8] = st_rep[b[1:0]*8 +: 8];  // only the addressed word
            end
        end
    end

endmodule

/* dcache_ctrl.sv */
`timescale 1ns/10ps

module dcache_ctrl import mem_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    access,     // aligned access present
    input  logic    is_store,
    input  addr_t   addr,       // access address
    input  tag_t    tag0,
    input  tag_t    tag1,
    input  logic    valid0,
    input  logic    valid1,
    input  logic    dirty0,
    input  logic    dirty1,
    input  logic    lru,        // next victim way
    input  line_t   line0,
    input  line_t   line1,
    output logic    we0,        // way 0 write strobe
    output logic    we1,        // way 1 write strobe
    output logic    fill_sel,   // 1 refill line, 0 store line
    output logic    dirty_wd,   // dirty bit written with the line
    output logic    lru_we,
    output logic    hit_way,    // way in use, victim outside idle
    output line_t   fill_line,  // refill line from l2
    output logic    miss_stall,
    output logic    l2_req,
    output l2_req_t l2,
    input  logic    l2_ack,
    input  line_t   l2_rdata
);

    dc_state_e state;
    dc_state_e state_nx;
    tag_t      tag;             // tag of the access
    index_t    index;           // set of the access
    logic      hit0;
    logic      hit1;
    logic      hit;
    logic      miss;            // lookup missed in idle
    logic      vict_dirty;      // victim must go back to l2
    tag_t      vict_tag;
    line_t     vict_line;
    logic      wr_hit;          // store hit this cycle
    logic      wr_fill;         // refill write this cycle

    assign tag   = addr[31:12];
    assign index = addr[11:4];

    assign hit0 = valid0 && (tag0 == tag);
    assign hit1 = valid1 && (tag1 == tag);
    assign hit  = hit0 || hit1;
    assign miss = (state == DC_IDLE) && access && !hit;

    assign vict_dirty = lru ? (valid1 && dirty1) : (valid0 && dirty0);
    assign vict_tag   = lru ? tag1 : tag0;
    assign vict_line  = lru ? line1 : line0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= DC_IDLE;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            DC_IDLE:    if (miss) state_nx = vict_dirty ? DC_WB_REQ : DC_RF_REQ;
            DC_WB_REQ:  if (l2_ack) state_nx = DC_WB_WAIT;     // ack seen, drop req
            DC_WB_WAIT: if (!l2_ack) state_nx = DC_RF_REQ;
            DC_RF_REQ:  if (l2_ack) state_nx = DC_RF_WAIT;     // rdata taken here
            DC_RF_WAIT: if (!l2_ack) state_nx = DC_FILL;
            DC_FILL:    state_nx = DC_IDLE;                    // access hits next cycle
            default:    state_nx = DC_IDLE;
        endcase
    end

    // request fields load one edge before req rises and hold to ack
    always_ff @(posedge clk) begin
        if (miss) begin
            l2.we    <= vict_dirty;
            l2.addr  <= vict_dirty ? {vict_tag, index, offset_t'(0)}
                                   : {tag, index, offset_t'(0)};
            l2.wdata <= vict_line;
        end else if ((state == DC_WB_WAIT) && !l2_ack) begin
            l2.we    <= 1'b0;                                  // now the refill read
            l2.addr  <= {tag, index, offset_t'(0)};
        end
        if ((state == DC_RF_REQ) && l2_ack) begin
            fill_line <= l2_rdata;                             // latched on ack rise
        end
    end

    assign l2_req     = (state == DC_WB_REQ) || (state == DC_RF_REQ);
    assign miss_stall = (state != DC_IDLE) || miss;

    assign wr_hit  = (state == DC_IDLE) && access && hit && is_store;
    assign wr_fill = (state == DC_FILL);

    assign hit_way  = (state == DC_IDLE) ? hit1 : lru;         // fill goes to the victim
    assign we0      = (wr_hit && !hit1) || (wr_fill && !lru);
    assign we1      = (wr_hit && hit1) || (wr_fill && lru);
    assign fill_sel = wr_fill;
    assign dirty_wd = !wr_fill;                                // store sets, fill clears
    assign lru_we   = ((state == DC_IDLE) && access && hit) || wr_fill;

endmodule

/* dcache_array.sv */
`timescale 1ns/10ps

module dcache_array import mem_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  index_t index,       // set for read and write
    input  logic   we0,
    input  logic   we1,
    input  tag_t   wtag,
    input  line_t  wline,
    input  logic   wdirty,
    input  logic   lru_we,
    input  logic   lru_wd,      // new victim way
    output tag_t   tag0,
    output tag_t   tag1,
    output logic   valid0,
    output logic   valid1,
    output logic   dirty0,
    output logic   dirty1,
    output logic   lru,
    output line_t  line0,
    output line_t  line1
);

    tag_t                     tag_mem  [2][NUM_SETS];  // per way tags
    line_t                    line_mem [2][NUM_SETS];  // per way lines
    logic [1:0][NUM_SETS-1:0] valid_q;
    logic [1:0][NUM_SETS-1:0] dirty_q;
    logic [NUM_SETS-1:0]      lru_q;                   // 1 means way 1 goes next
    logic [1:0]               we;

    assign we = {we1, we0};

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (we[w]) begin
                tag_mem[w][index]  <= wtag;
                line_mem[w][index] <= wline;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (we[w]) begin
                    valid_q[w][index] <= 1'b1;                 // any write validates
                    dirty_q[w][index] <= wdirty;
                end
            end
            if (lru_we) begin
                lru_q[index] <= lru_wd;
            end
        end
    end

    // combinational read, same cycle lookup
    assign tag0   = tag_mem[0][index];
    assign tag1   = tag_mem[1][index];
    assign line0  = line_mem[0][index];
    assign line1  = line_mem[1][index];
    assign valid0 = valid_q[0][index];
    assign valid1 = valid_q[1][index];
    assign dirty0 = dirty_q[0][index];
    assign dirty1 = dirty_q[1][index];
    assign lru    = lru_q[index];

endmodule

/* mem_wb_reg.sv */
`timescale 1ns/10ps

module mem_wb_reg import mem_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    stall,      // pipeline stall
    input  logic    flush,      // pipeline flush
    input  logic    miss_stall, // cache miss in progress
    input  ex_mem_t ex,
    input  word_t   out,        // aligned load data or alu result
    input  logic    misalign,
    output mem_wb_t wb
);

    logic drop_q;               // flushed while held, discard on capture

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb     <= '0;
            drop_q <= 1'b0;
        end else if (flush) begin
            wb.en  <= 1'b0;
            drop_q <= stall || miss_stall;                     // held access is dead
        end else if (!stall && !miss_stall) begin
            wb.en       <= ex.en && !drop_q;
            wb.dst_addr <= ex.dst_addr;
            wb.gpr_we   <= ex.gpr_we && !misalign;             // no write on a trap
            wb.out      <= out;
            wb.misalign <= misalign;
            drop_q      <= 1'b0;
        end
    end

endmodule

/* mem_stage.sv */
`timescale 1ns/10ps

module mem_stage import mem_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    stall,
    input  logic    flush,
    input  ex_mem_t ex,         // ex/mem pipeline register
    output logic    miss_stall, // stall request to the pipeline
    output word_t   fwd_data,   // result for forwarding
    output mem_wb_t wb,         // mem/wb pipeline register
    output logic    l2_req,
    output l2_req_t l2,
    input  logic    l2_ack,
    input  line_t   l2_rdata
);

    word_t out;
    line_t st_line;
    logic  misalign;
    logic  access;
    logic  is_store;
    tag_t  tag0;
    tag_t  tag1;
    logic  valid0;
    logic  valid1;
    logic  dirty0;
    logic  dirty1;
    logic  lru;
    line_t line0;
    line_t line1;
    logic  we0;
    logic  we1;
    logic  fill_sel;
    logic  dirty_wd;
    logic  lru_we;
    logic  hit_way;
    line_t fill_line;
    line_t hit_line;            // line of the way in use
    line_t wline;               // array write data

    assign fwd_data = out;
    assign hit_line = hit_way ? line1 : line0;
    assign wline    = fill_sel ? fill_line : st_line;

    mem_align u_align (
        .ex       (ex),
        .hit_line (hit_line),
        .out      (out),
        .st_line  (st_line),
        .misalign (misalign),
        .access   (access),
        .is_store (is_store)
    );

    dcache_ctrl u_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .access     (access),
        .is_store   (is_store),
        .addr       (ex.addr),
        .tag0       (tag0),
        .tag1       (tag1),
        .valid0     (valid0),
        .valid1     (valid1),
        .dirty0     (dirty0),
        .dirty1     (dirty1),
        .lru        (lru),
        .line0      (line0),
        .line1      (line1),
        .we0        (we0),
        .we1        (we1),
        .fill_sel   (fill_sel),
        .dirty_wd   (dirty_wd),
        .lru_we     (lru_we),
        .hit_way    (hit_way),
        .fill_line  (fill_line),
        .miss_stall (miss_stall),
        .l2_req     (l2_req),
        .l2         (l2),
        .l2_ack     (l2_ack),
        .l2_rdata   (l2_rdata)
    );

    dcache_array u_array (
        .clk    (clk),
        .arst_n (arst_n),
        .index  (ex.addr[11:4]),
        .we0    (we0),
        .we1    (we1),
        .wtag   (ex.addr[31:12]),
        .wline  (wline),
        .wdirty (dirty_wd),
        .lru_we (lru_we),
        .lru_wd (~hit_way),     // other way becomes the victim
        .tag0   (tag0),
        .tag1   (tag1),
        .valid0 (valid0),
        .valid1 (valid1),
        .dirty0 (dirty0),
        .dirty1 (dirty1),
        .lru    (lru),
        .line0  (line0),
        .line1  (line1)
    );

    mem_wb_reg u_wb_reg (
        .clk        (clk),
        .arst_n     (arst_n),
        .stall      (stall),
        .flush      (flush),
        .miss_stall (miss_stall),
        .ex         (ex),
        .out        (out),
        .misalign   (misalign),
        .wb         (wb)
    );

endmodule

/* mem_stage_sva.sv */
`timescale 1ns/10ps

module mem_stage_sva import mem_pkg::*; (
    input logic    clk,
    input logic    arst_n,
    input logic    stall,
    input logic    flush,
    input logic    miss_stall,
    input mem_wb_t wb,
    input logic    l2_req,
    input l2_req_t l2,
    input logic    l2_ack
);

    req_held: assert property (@(posedge clk) disable iff (!arst_n)
        l2_req && !l2_ack |=> l2_req)
        else $error("l2_req dropped before l2_ack");

    ack_with_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(l2_ack) |-> l2_req)
        else $error("l2_ack rose without l2_req");

    fields_stable: assert property (@(posedge clk) disable iff (!arst_n)
        l2_req && !l2_ack && $past(l2_req) |-> $stable(l2))
        else $error("l2 request fields changed before ack");

    wb_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (stall || miss_stall) && !flush |=> $stable(wb))
        else $error("wb changed during a stall");

    quiet_after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> !l2_req && !wb.en)
        else $error("req or wb.en active right after reset");

endmodule

bind mem_stage mem_stage_sva u_sva (.*);

/* tb_mem_stage.sv */
`timescale 1ns/10ps

module tb_mem_stage import mem_pkg::*; ();

    logic    clk;
    logic    arst_n;
    logic    stall;
    logic    flush;
    ex_mem_t ex;
    logic    miss_stall;
    word_t   fwd_data;
    mem_wb_t wb;
    logic    l2_req;
    l2_req_t l2;
    logic    l2_ack;
    line_t   l2_rdata;

    word_t       l2_mem [addr_t];       // sparse l2 holding only written words
    logic [31:0] lfsr_state;
    int          value_errors;
    int          req_count;             // l2 requests seen by the model
    int          wb_count;              // writebacks seen by the model
    int          access_count;

    mem_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;         // 40 ns period
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // never written words read back as their own address scrambled
    function automatic word_t l2_word(input addr_t a);
        if (l2_mem.exists(a)) return l2_mem[a];
        return a ^ 32'h5a5a_0000;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s did not happen in time, run stopped", what);
        $display("TEST FAILED");
        $finish;
    endtask

    // four phase l2 model with random ack delay
    initial begin
        logic [31:0] delay;
        int          n;
        l2_ack   = 1'b0;
        l2_rdata = '0;
        forever begin
            @(negedge clk);
            if (arst_n && l2_req && !l2_ack) begin
                req_count++;
                delay = rand_bits(2);                           // 0 to 3 cycles
                if (l2.we) begin
                    wb_count++;
                    for (int i = 0; i < 4; i++) begin
                        l2_mem[l2.addr + 32'(4 * i)] = l2.wdata[i*32 +: 32];
                    end
                end else begin
                    for (int i = 0; i < 4; i++) begin
                        l2_rdata[i*32 +: 32] = l2_word(l2.addr + 32'(4 * i));
                    end
                end
                @(posedge clk);
                repeat (delay) @(posedge clk);
                #1 l2_ack = 1'b1;
                n = 0;
                while (l2_req) begin                            // controller drops req
                    @(negedge clk);
                    n++;
                    if (n > 50) abort_on_timeout("l2 req release");
                end
                @(posedge clk);
                #1 l2_ack = 1'b0;
            end
        end
    end

    // ctl 0 plain, 1 misaligned, 2 flush in miss, 3 stall on hit, 4 writeback expected
    task automatic run_access(input int ctl, input int miss_exp, input logic [31:0] op,
                              input addr_t addr, input word_t wdata, input word_t exp);
        mem_wb_t saved;
        int      reqs_before;
        int      wbs_before;
        logic    seen_miss;
        logic    flushed;
        word_t   fwd;
        int      n;
        access_count++;
        ex.en       = 1'b1;
        ex.op       = mem_op_e'(op[3:0]);
        ex.addr     = (ctl == 1) ? {~addr[31:12], addr[11:0]} : addr;  // tag never cached
        ex.wr_data  = wdata;
        ex.dst_addr = reg_addr_t'(access_count);
        ex.gpr_we   = 1'b1;
        saved       = wb;
        reqs_before = req_count;
        wbs_before  = wb_count;
        seen_miss   = 1'b0;
        flushed     = 1'b0;
        fwd         = '0;
        if (ctl == 3) begin
            stall = 1'b1;
            repeat (2) begin
                @(posedge clk);
                #1 check_value("wb held in stall", 64'(wb), 64'(saved));
            end
            stall = 1'b0;
        end
        n = 0;
        forever begin
            @(negedge clk);
            fwd = fwd_data;
            if (!miss_stall) break;
            seen_miss = 1'b1;
            if (ctl == 2 && !flushed) begin
                flushed = 1'b1;
                @(posedge clk);
                #1 flush = 1'b1;
                @(posedge clk);
                #1 flush = 1'b0;
            end
            n++;
            if (n > 200) abort_on_timeout("miss completion");
        end
        @(posedge clk);
        #1;
        check_value("miss seen", 64'(seen_miss), 64'(miss_exp));
        if (ctl == 2) begin
            check_value("flushed wb.en", 64'(wb.en), 64'd0);
        end else begin
            check_value("wb.en", 64'(wb.en), 64'd1);
            check_value("wb.dst_addr", 64'(wb.dst_addr), 64'(access_count % 32));
            check_value("wb.misalign", 64'(wb.misalign), 64'(ctl == 1));
            check_value("wb.gpr_we", 64'(wb.gpr_we), 64'(ctl != 1));
        end
        if (ctl == 1) check_value("l2 reqs on misalign", 64'(req_count), 64'(reqs_before));
        if (ctl != 1 && ctl != 2) begin
            check_value("wb.out", 64'(wb.out), 64'(exp));
            check_value("fwd_data", 64'(fwd), 64'(exp));
        end
        if (ctl == 4) check_value("writebacks", 64'(wb_count), 64'(wbs_before + 1));
    endtask

    initial begin
        int          fd;
        string       line;
        int          ctl;
        int          miss_exp;
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp;
        lfsr_state   = 32'h46e4_b30a;
        value_errors = 0;
        req_count    = 0;
        wb_count     = 0;
        access_count = 0;
        arst_n = 1'b0;
        stall  = 1'b0;
        flush  = 1'b0;
        ex     = '0;
        repeat (3) @(posedge clk);
        #1 arst_n = 1'b1;
        fd = $fopen("mem_stage_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open mem_stage_testdata.txt, no stimulus");
            value_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() == 0 || line.getc(0) == 8'h23) continue;   // comment
                if ($sscanf(line, "%d %d %h %h %h %h", ctl, miss_exp, op, addr, wdata, exp)
                    != 6) continue;
                run_access(ctl, miss_exp, op, addr, wdata, exp);
            end
            $fclose(fd);
        end
        ex = '0;
        repeat (2) @(posedge clk);
        $display("accesses %0d, l2 requests %0d, writebacks %0d, errors %0d",
                 access_count, req_count, wb_count, value_errors);
        if (value_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* mem_stage_testdata.txt */
# ctl miss op addr wr_data expected  (hex from op on)
# ctl 0 plain, 1 misaligned, 2 flush in miss, 3 stall on hit, 4 dirty eviction
0 1 1 00001040 00000000 5a5a1040
0 0 1 0000104c 00000000 5a5a104c
0 0 8 00001041 000000a5 00001041
0 0 7 00001046 00008123 00001046
0 0 6 00001048 f00dbeef 00001048
0 0 1 00001040 00000000 5a5aa540
0 0 4 00001041 00000000 ffffffa5
0 0 5 00001041 00000000 000000a5
0 0 2 00001046 00000000 ffff8123
0 0 3 00001046 00000000 00008123
0 0 4 00001048 00000000 ffffffef
0 0 5 0000104b 00000000 000000f0
0 0 2 0000104a 00000000 fffff00d
0 0 3 00001048 00000000 0000beef
0 1 1 00002040 00000000 5a5a2040
4 1 1 00003040 00000000 5a5a3040
0 1 1 00001048 00000000 f00dbeef
0 0 1 00001040 00000000 5a5aa540
0 0 3 00001044 00000000 00001044
1 0 1 00001042 00000000 00000000
1 0 7 00001043 0000ffff 00000000
1 0 2 00003041 00000000 00000000
2 1 1 00005080 00000000 00000000
0 0 1 00005080 00000000 5a5a5080
3 0 1 00005084 00000000 5a5a5084
3 0 5 00003040 00000000 00000040
0 1 1 00008ff0 00000000 5a5a8ff0
0 0 6 00008ff4 12345678 00008ff4
0 0 1 00008ff4 00000000 12345678

/* build.f */
mem_pkg.sv
mem_align.sv
dcache_ctrl.sv
dcache_array.sv
mem_wb_reg.sv
mem_stage.sv
mem_stage_sva.sv
tb_mem_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
